// File: src/ooo_pkg.sv
package ooo_pkg;

    // Datapath sizes
    localparam int WORD_W            = 32;    // Operand and result width
    localparam int REG_IDX_W         = 5;     // 32 architectural registers
    localparam int DEFAULT_ROB_DEPTH = 8;     // Reorder buffer entries, power of two

    typedef logic [WORD_W-1:0]    word_t;     // Operand, result, retired value
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // Destination register index

    // Decoded operations, arrive from the front end
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,   // a + b
        OP_SUB = 3'd1,   // a - b
        OP_AND = 3'd2,   // a & b
        OP_XOR = 3'd3,   // a ^ b
        OP_MUL = 3'd4,   // Low word of a * b
        OP_DIV = 3'd5,   // Unsigned quotient
        OP_REM = 3'd6    // Unsigned remainder
    } opcode_t;

    // Result bus requesters, also the issue target
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_t;

endpackage

// File: src/alu_unit.sv
module alu_unit #(
    parameter int TAG_W = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  ooo_pkg::opcode_t  op,
    input  logic [TAG_W-1:0]  tag,
    input  ooo_pkg::word_t    a,
    input  ooo_pkg::word_t    b,
    input  logic              grant,
    output logic              ready_in,
    output logic              req,
    output logic [TAG_W-1:0]  res_tag,
    output ooo_pkg::word_t    res_value,
    output logic              res_except
);
    import ooo_pkg::*;

    word_t result;                               // Combinational ALU output

    assign ready_in   = !req || grant;           // Free, or slot drains this edge
    assign res_except = 1'b0;                    // ALU ops never trap

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_XOR:  result = a ^ b;
            default: result = a + b;             // Not steered here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else if (flush) begin
            req <= 1'b0;                         // Drop held result
        end else if (start) begin
            req <= 1'b1;                         // New result replaces granted one
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_tag   <= tag;                    // Holding register
            res_value <= result;
        end
    end

endmodule

// File: src/mul_unit.sv
module mul_unit #(
    parameter int TAG_W = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  logic [TAG_W-1:0]  tag,
    input  ooo_pkg::word_t    a,
    input  ooo_pkg::word_t    b,
    input  logic              grant,
    output logic              ready_in,
    output logic              req,
    output logic [TAG_W-1:0]  res_tag,
    output ooo_pkg::word_t    res_value,
    output logic              res_except
);
    import ooo_pkg::*;

    logic             v1, v2, v3;               // Stage valids
    logic             advance;                  // Whole pipe moves
    logic [TAG_W-1:0] t1, t2;                   // Tags riding with data
    word_t            a1, b1;                   // Stage 1 operands
    word_t            p_lo;                     // a * b[15:0], low word
    logic [15:0]      p_hi;                     // a[15:0] * b[31:16], low half
    word_t            prod;

    assign advance    = !v3 || grant;           // Last stage empty or draining
    assign ready_in   = advance || !v1;         // Stage 1 can still fill while held
    assign req        = v3;
    assign res_except = 1'b0;
    // Only the low 16 bits of the upper partial reach the low word
    assign prod       = p_lo + {p_hi, 16'h0000};

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (flush) begin
            v1 <= 1'b0;                         // Kill everything in flight
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (advance) begin
            v3 <= v2;
            v2 <= v1;
            v1 <= start;
        end else if (!v1) begin
            v1 <= start;                        // Fill bubble under a held tail
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            res_tag   <= t2;                    // Stage 3 result
            res_value <= prod;
            t2        <= t1;                    // Stage 2 partial products
            p_lo      <= a1 * {16'h0000, b1[15:0]};
            p_hi      <= a1[15:0] * b1[31:16];
        end
        if (ready_in) begin
            t1 <= tag;                          // Stage 1 capture
            a1 <= a;
            b1 <= b;
        end
    end

endmodule

// File: src/div_unit.sv
module div_unit #(
    parameter int TAG_W = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  ooo_pkg::opcode_t  op,
    input  logic [TAG_W-1:0]  tag,
    input  ooo_pkg::word_t    a,
    input  ooo_pkg::word_t    b,
    input  logic              grant,
    output logic              ready_in,
    output logic              req,
    output logic [TAG_W-1:0]  res_tag,
    output ooo_pkg::word_t    res_value,
    output logic              res_except
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {IDLE, CALC, DONE} state_t;

    state_t      state;
    logic [4:0]  cnt;                            // Remaining quotient bits
    word_t       quo;                            // Dividend shifts out, quotient in
    word_t       rem;                            // Partial remainder
    word_t       dvs;                            // Divisor
    logic        is_rem;                         // Return remainder
    logic [32:0] trial;                          // Restoring subtract, bit 32 is borrow

    assign trial     = {rem, quo[31]} - {1'b0, dvs};
    assign ready_in  = (state == IDLE);
    assign req       = (state == DONE);
    assign res_value = is_rem ? rem : quo;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;                       // Abandon any division
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        if (b == '0 || a < b) begin
                            state <= DONE;       // Trivial result, no iteration
                        end else begin
                            state <= CALC;
                        end
                    end
                end
                CALC:    if (cnt == 5'd0) state <= DONE;
                DONE:    if (grant) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            res_tag    <= tag;
            is_rem     <= (op == OP_REM);
            dvs        <= b;
            cnt        <= 5'd31;                 // 32 iterations
            res_except <= (b == '0);
            if (b == '0) begin
                quo <= '1;                       // Divide by zero gives all ones
                rem <= '1;
            end else if (a < b) begin
                quo <= '0;
                rem <= a;
            end else begin
                quo <= a;
                rem <= '0;
            end
        end else if (state == CALC) begin
            cnt <= cnt - 5'd1;
            quo <= {quo[30:0], !trial[32]};      // Quotient bit set when no borrow
            rem <= trial[32] ? {rem[30:0], quo[31]} : trial[31:0];
        end
    end

endmodule

// File: src/result_bus_arbiter.sv
module result_bus_arbiter #(
    parameter int TAG_W = 3
) (
    input  logic              alu_req,
    input  logic [TAG_W-1:0]  alu_tag,
    input  ooo_pkg::word_t    alu_value,
    input  logic              alu_except,
    input  logic              mul_req,
    input  logic [TAG_W-1:0]  mul_tag,
    input  ooo_pkg::word_t    mul_value,
    input  logic              mul_except,
    input  logic              div_req,
    input  logic [TAG_W-1:0]  div_tag,
    input  ooo_pkg::word_t    div_value,
    input  logic              div_except,
    output logic              alu_grant,
    output logic              mul_grant,
    output logic              div_grant,
    output logic              bus_valid,
    output logic [TAG_W-1:0]  bus_tag,
    output ooo_pkg::word_t    bus_value,
    output logic              bus_except
);
    import ooo_pkg::*;

    unit_t sel;                                  // Winning requester

    // Divider first since it blocks new work while held
    always_comb begin
        if (div_req) begin
            sel = UNIT_DIV;
        end else if (mul_req) begin
            sel = UNIT_MUL;                      // A held mul freezes its pipe
        end else begin
            sel = UNIT_ALU;
        end
    end

    assign div_grant = div_req && (sel == UNIT_DIV);
    assign mul_grant = mul_req && (sel == UNIT_MUL);
    assign alu_grant = alu_req && (sel == UNIT_ALU);
    assign bus_valid = alu_req || mul_req || div_req;

    always_comb begin
        case (sel)
            UNIT_DIV: begin
                bus_tag    = div_tag;
                bus_value  = div_value;
                bus_except = div_except;
            end
            UNIT_MUL: begin
                bus_tag    = mul_tag;
                bus_value  = mul_value;
                bus_except = mul_except;
            end
            default: begin
                bus_tag    = alu_tag;
                bus_value  = alu_value;
                bus_except = alu_except;
            end
        endcase
    end

endmodule

// File: src/reorder_buffer.sv
module reorder_buffer #(
    parameter  int ROB_DEPTH = ooo_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  ooo_pkg::reg_idx_t  alloc_dest,
    input  logic               alloc_except,
    input  logic               bus_valid,
    input  logic [TAG_W-1:0]   bus_tag,
    input  ooo_pkg::word_t     bus_value,
    input  logic               bus_except,
    output logic [TAG_W-1:0]   alloc_tag,
    output logic               full,
    output logic               flush,
    output logic               retire_valid,
    output logic [TAG_W-1:0]   retire_tag,
    output ooo_pkg::reg_idx_t  retire_dest,
    output ooo_pkg::word_t     retire_value,
    output logic               exception_valid,
    output logic [TAG_W-1:0]   exception_tag
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] busy;                  // Entry allocated
    logic [ROB_DEPTH-1:0] ready;                 // Result written
    logic [ROB_DEPTH-1:0] except;                // Entry traps at head
    reg_idx_t             dest_mem  [ROB_DEPTH];
    word_t                value_mem [ROB_DEPTH];

    logic [TAG_W:0]   head;                      // Extra wrap bit
    logic [TAG_W:0]   tail;
    logic [TAG_W-1:0] head_idx;
    logic             ptr_full;
    logic             head_done;                 // Head can leave this edge
    logic             head_trap;                 // Head leaves by exception
    logic             bus_hit;                   // Result lands in a live entry

    assign head_idx  = head[TAG_W-1:0];
    assign alloc_tag = tail[TAG_W-1:0];          // Tail is the next tag
    assign ptr_full  = (head[TAG_W] != tail[TAG_W]) && (head_idx == alloc_tag);
    assign head_done = busy[head_idx] && ready[head_idx];
    assign head_trap = head_done && except[head_idx];
    // No allocation on the trap edge, the new entry would be lost
    assign full      = ptr_full || head_trap;
    assign bus_hit   = bus_valid && busy[bus_tag] && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            head            <= '0;
            tail            <= '0;
            busy            <= '0;
            ready           <= '0;
            except          <= '0;
            flush           <= 1'b0;
            retire_valid    <= 1'b0;
            exception_valid <= 1'b0;
        end else begin
            flush           <= 1'b0;             // Pulses by default
            retire_valid    <= 1'b0;
            exception_valid <= 1'b0;
            if (alloc_valid) begin
                busy[alloc_tag]   <= 1'b1;
                ready[alloc_tag]  <= alloc_except;   // Issue trap is born ready
                except[alloc_tag] <= alloc_except;
                tail              <= tail + 1'b1;
            end
            if (bus_hit) begin
                ready[bus_tag]  <= 1'b1;
                except[bus_tag] <= bus_except;
            end
            if (head_trap) begin
                busy            <= '0;           // Drop head and everything younger
                ready           <= '0;
                except          <= '0;
                head            <= '0;
                tail            <= '0;
                flush           <= 1'b1;
                exception_valid <= 1'b1;
            end else if (head_done) begin
                busy[head_idx] <= 1'b0;          // In-order retire
                head           <= head + 1'b1;
                retire_valid   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            dest_mem[alloc_tag] <= alloc_dest;
        end
        if (bus_hit) begin
            value_mem[bus_tag] <= bus_value;     // Write by tag
        end
        if (head_done) begin
            retire_tag    <= head_idx;
            retire_dest   <= dest_mem[head_idx];
            retire_value  <= value_mem[head_idx];
            exception_tag <= head_idx;           // Meaningful with exception_valid
        end
    end

endmodule

// File: src/ooo_core_top.sv
module ooo_core_top #(
    parameter  int ROB_DEPTH = ooo_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  ooo_pkg::opcode_t   issue_op,
    input  ooo_pkg::reg_idx_t  issue_dest,
    input  ooo_pkg::word_t     issue_a,
    input  ooo_pkg::word_t     issue_b,
    input  logic               issue_except,
    output logic               issue_stall,
    output logic               retire_valid,
    output logic [TAG_W-1:0]   retire_tag,
    output ooo_pkg::reg_idx_t  retire_dest,
    output ooo_pkg::word_t     retire_value,
    output logic               exception_valid,
    output logic [TAG_W-1:0]   exception_tag
);
    import ooo_pkg::*;

    unit_t            issue_unit;                // Decoded target
    logic             unit_ready;
    logic             accept;                    // Instruction taken this edge
    logic             to_unit;                   // Accepted and needs execution
    logic             rob_full, flush;
    logic [TAG_W-1:0] alloc_tag;
    logic             alu_start, alu_ready, alu_req, alu_grant, alu_except;
    logic             mul_start, mul_ready, mul_req, mul_grant, mul_except;
    logic             div_start, div_ready, div_req, div_grant, div_except;
    logic [TAG_W-1:0] alu_tag, mul_tag, div_tag, bus_tag;
    word_t            alu_value, mul_value, div_value, bus_value;
    logic             bus_valid, bus_except;

    always_comb begin
        case (issue_op)
            OP_MUL:         issue_unit = UNIT_MUL;
            OP_DIV, OP_REM: issue_unit = UNIT_DIV;
            default:        issue_unit = UNIT_ALU;
        endcase
        case (issue_unit)
            UNIT_MUL: unit_ready = mul_ready;
            UNIT_DIV: unit_ready = div_ready;
            default:  unit_ready = alu_ready;
        endcase
    end

    // Trapping issues skip the units, so their readiness does not matter
    assign issue_stall = rob_full || flush || (!issue_except && !unit_ready);
    assign accept      = issue_valid && !issue_stall;
    assign to_unit     = accept && !issue_except;
    assign alu_start   = to_unit && (issue_unit == UNIT_ALU);
    assign mul_start   = to_unit && (issue_unit == UNIT_MUL);
    assign div_start   = to_unit && (issue_unit == UNIT_DIV);

    alu_unit #(.TAG_W(TAG_W)) alu0 (
        .clk, .rst, .flush, .start(alu_start), .op(issue_op), .tag(alloc_tag),
        .a(issue_a), .b(issue_b), .grant(alu_grant), .ready_in(alu_ready), .req(alu_req),
        .res_tag(alu_tag), .res_value(alu_value), .res_except(alu_except));

    mul_unit #(.TAG_W(TAG_W)) mul0 (
        .clk, .rst, .flush, .start(mul_start), .tag(alloc_tag),
        .a(issue_a), .b(issue_b), .grant(mul_grant), .ready_in(mul_ready), .req(mul_req),
        .res_tag(mul_tag), .res_value(mul_value), .res_except(mul_except));

    div_unit #(.TAG_W(TAG_W)) div0 (
        .clk, .rst, .flush, .start(div_start), .op(issue_op), .tag(alloc_tag),
        .a(issue_a), .b(issue_b), .grant(div_grant), .ready_in(div_ready), .req(div_req),
        .res_tag(div_tag), .res_value(div_value), .res_except(div_except));

    result_bus_arbiter #(.TAG_W(TAG_W)) arb0 (
        .alu_req, .alu_tag, .alu_value, .alu_except,
        .mul_req, .mul_tag, .mul_value, .mul_except,
        .div_req, .div_tag, .div_value, .div_except,
        .alu_grant, .mul_grant, .div_grant,
        .bus_valid, .bus_tag, .bus_value, .bus_except);

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob0 (
        .clk, .rst, .alloc_valid(accept), .alloc_dest(issue_dest),
        .alloc_except(issue_except), .bus_valid, .bus_tag, .bus_value, .bus_except,
        .alloc_tag, .full(rob_full), .flush, .retire_valid, .retire_tag, .retire_dest,
        .retire_value, .exception_valid, .exception_tag);

endmodule

// File: testbench/tb_ooo_core.sv
module tb_ooo_core;
    import ooo_pkg::*;

    localparam int ROB_DEPTH      = 8;
    localparam int TAG_W          = $clog2(ROB_DEPTH);
    localparam int NUM_ENTRIES    = 34;                   // Rows in the stimulus table
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 200;

    logic             clk, rst;
    logic             issue_valid, issue_except, issue_stall;
    opcode_t          issue_op;
    reg_idx_t         issue_dest, retire_dest;
    word_t            issue_a, issue_b, retire_value;
    logic             retire_valid, exception_valid;
    logic [TAG_W-1:0] retire_tag, exception_tag;

    // Stimulus table with one row per instruction
    int       tab_test  [NUM_ENTRIES];
    opcode_t  tab_op    [NUM_ENTRIES];
    reg_idx_t tab_dest  [NUM_ENTRIES];
    word_t    tab_a     [NUM_ENTRIES];
    word_t    tab_b     [NUM_ENTRIES];
    logic     tab_exc   [NUM_ENTRIES];                    // Issue-time exception flag
    logic     tab_rnd   [NUM_ENTRIES];                    // Operands from $random
    logic     tab_wait  [NUM_ENTRIES];                    // Issue once nothing is outstanding
    logic     tab_stall [NUM_ENTRIES];                    // Stall must show before acceptance
    int       n_tab = 0;

    // Reference model state in issue order
    word_t            exp_val  [$];
    reg_idx_t         exp_dest [$];
    logic             exp_exc  [$];
    logic [TAG_W-1:0] exp_tag  [$];
    logic [TAG_W-1:0] next_tag = '0;                      // Mirrors the buffer tail
    int               seed = 32'h4210;
    int               checks = 0, errors = 0, flushed = 0, test_base = 0;

    ooo_core_top #(.ROB_DEPTH(ROB_DEPTH)) dut0 (
        .clk, .rst, .issue_valid, .issue_op, .issue_dest, .issue_a, .issue_b,
        .issue_except, .issue_stall, .retire_valid, .retire_tag, .retire_dest,
        .retire_value, .exception_valid, .exception_tag);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t actual, input reg_idx_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] actual,
                             input logic [TAG_W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Operation rules with unsigned division and all ones for a zero divisor
    function automatic word_t expect_value(input opcode_t op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;                        // Low word only
            OP_DIV:  return (b == '0) ? '1 : a / b;
            OP_REM:  return (b == '0) ? '1 : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset and ALU in order";
            2:       return "reverse finish in order";
            3:       return "result bus contention";
            4:       return "divide burst";
            5:       return "divide by zero flush";
            default: return "issue exception";
        endcase
    endfunction

    task automatic add_entry(input int t, input opcode_t op, input reg_idx_t d, input word_t a,
                             input word_t b, input logic exc, input logic rnd, input logic wt,
                             input logic st);
        tab_test[n_tab]  = t;
        tab_op[n_tab]    = op;
        tab_dest[n_tab]  = d;
        tab_a[n_tab]     = a;
        tab_b[n_tab]     = b;
        tab_exc[n_tab]   = exc;
        tab_rnd[n_tab]   = rnd;
        tab_wait[n_tab]  = wt;
        tab_stall[n_tab] = st;
        n_tab++;
    endtask

    task automatic load_table();
        int i;
        add_entry(1, OP_ADD, 5'd1, 32'd5, 32'd7, 0, 0, 0, 0);
        add_entry(1, OP_SUB, 5'd2, 32'd100, 32'd1, 0, 0, 0, 0);
        add_entry(1, OP_AND, 5'd3, 32'hf0f0_1234, 32'h0ff0_ff00, 0, 0, 0, 0);
        add_entry(1, OP_XOR, 5'd4, 32'hdead_beef, 32'h1234_5678, 0, 0, 0, 0);
        add_entry(2, OP_DIV, 5'd5, 32'd1000000, 32'd7, 0, 0, 0, 0);      // Slowest first
        add_entry(2, OP_MUL, 5'd6, 32'd1234, 32'd5678, 0, 0, 0, 0);
        add_entry(2, OP_ADD, 5'd7, 32'd1, 32'd2, 0, 0, 0, 0);
        for (i = 0; i < 8; i++) begin                    // Mul pairs meet ALU pairs on the bus
            add_entry(3, (i % 4 < 2) ? OP_MUL : opcode_t'((i / 4) * 2 + i % 2), 5'(8 + i),
                      '0, '0, 0, 1, 0, 0);
        end
        for (i = 0; i < 9; i++) begin                    // Last one must see a stall
            add_entry(4, (i % 3 == 2) ? OP_REM : OP_DIV, 5'(16 + i),
                      32'h0001_0000 + i * 977, word_t'(i + 3), 0, 0, 0, i == 8);
        end
        add_entry(5, OP_MUL, 5'd20, 32'd3, 32'd4, 0, 0, 0, 0);           // Keeps the head busy
        add_entry(5, OP_ADD, 5'd21, 32'd10, 32'd20, 0, 0, 0, 0);
        add_entry(5, OP_DIV, 5'd22, 32'd55, 32'd0, 0, 0, 0, 0);          // Traps at head
        add_entry(5, OP_ADD, 5'd23, 32'd1, 32'd1, 0, 0, 0, 0);
        add_entry(5, OP_ADD, 5'd24, 32'd2, 32'd2, 0, 0, 0, 0);
        add_entry(5, OP_ADD, 5'd25, 32'd3, 32'd3, 0, 0, 1, 0);           // After the flush
        add_entry(6, OP_ADD, 5'd26, 32'd9, 32'd1, 0, 0, 0, 0);
        add_entry(6, OP_ADD, 5'd27, 32'd4, 32'd4, 1, 0, 0, 0);           // Born excepting
        add_entry(6, OP_SUB, 5'd28, 32'd8, 32'd3, 0, 0, 0, 0);
        add_entry(6, OP_XOR, 5'd29, 32'h00ff, 32'h0f0f, 0, 0, 1, 0);
    endtask

    // Runs from posedge + 1 to the posedge + 1 after acceptance
    task automatic issue_entry(input int i);
        word_t a, b;
        logic  seen;
        logic  exc;
        a    = tab_a[i];
        b    = tab_b[i];
        seen = 1'b0;
        if (tab_rnd[i]) begin
            a = $random(seed);
            b = $random(seed);
        end
        if (tab_wait[i]) begin
            while (exp_val.size() != 0) begin
                @(posedge clk);
                #1;
            end
        end
        issue_valid  = 1'b1;
        issue_op     = tab_op[i];
        issue_dest   = tab_dest[i];
        issue_a      = a;
        issue_b      = b;
        issue_except = tab_exc[i];
        @(negedge clk);
        while (issue_stall) begin                        // Stall is settled mid cycle
            seen = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);                                  // Accepted on this edge
        exc = tab_exc[i] || ((tab_op[i] == OP_DIV || tab_op[i] == OP_REM) && b == '0);
        exp_val.push_back(expect_value(tab_op[i], a, b));
        exp_dest.push_back(tab_dest[i]);
        exp_exc.push_back(exc);
        exp_tag.push_back(next_tag);
        next_tag = next_tag + 1'b1;
        if (exp_val.size() > ROB_DEPTH) begin
            errors++;
            $display("More than %0d instructions outstanding after entry %0d", ROB_DEPTH, i);
        end
        if (tab_stall[i] && !seen) begin
            errors++;
            $display("Entry %0d was accepted without issue_stall being raised first", i);
        end
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic retire_seen();
        if (exp_val.size() == 0) begin
            errors++;
            $display("Retire of tag %h seen with no instruction outstanding", retire_tag);
        end else begin
            check_flag("exception_valid", exception_valid, exp_exc[0]);
            check_tag("retire_tag", retire_tag, exp_tag[0]);
            check_reg("retire_dest", retire_dest, exp_dest[0]);
            check_word("retire_value", retire_value, exp_val[0]);
            void'(exp_val.pop_front());
            void'(exp_dest.pop_front());
            void'(exp_exc.pop_front());
            void'(exp_tag.pop_front());
        end
    endtask

    task automatic exception_seen();
        if (exp_val.size() == 0) begin
            errors++;
            $display("Exception on tag %h seen with no instruction outstanding", exception_tag);
        end else begin
            check_flag("exception_valid", exception_valid, exp_exc[0]);
            check_tag("exception_tag", exception_tag, exp_tag[0]);
            flushed += exp_val.size() - 1;               // Younger entries are dropped
            exp_val.delete();
            exp_dest.delete();
            exp_exc.delete();
            exp_tag.delete();
            next_tag = '0;                               // Buffer restarts empty
        end
    endtask

    // Registered outputs sampled mid cycle
    always @(negedge clk) begin
        if (!rst && retire_valid) retire_seen();
        if (!rst && exception_valid) exception_seen();
    end

    task automatic finish_test(input int t);
        while (exp_val.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                       // Catch stray late retires
        #1;
        $display("Test %0d %s: %s, %0d errors", t, test_name(t),
                 (errors == test_base) ? "passed" : "failed", errors - test_base);
        test_base = errors;
    endtask

    initial begin
        int i;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = OP_ADD;
        issue_dest   = '0;
        issue_a      = '0;
        issue_b      = '0;
        issue_except = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("retire_valid", retire_valid, 1'b0);  // Idle after reset
        check_flag("exception_valid", exception_valid, 1'b0);
        check_flag("issue_stall", issue_stall, 1'b0);
        for (i = 0; i < NUM_ENTRIES; i++) begin
            if (i > 0 && tab_test[i] != tab_test[i-1]) finish_test(tab_test[i-1]);
            issue_entry(i);
        end
        finish_test(tab_test[NUM_ENTRIES-1]);
        $display("Totals: %0d checks, %0d errors, %0d flushed", checks, errors, flushed);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d results outstanding",
                 TIMEOUT_CYCLES, exp_val.size());
        $display("Errors found");
        $finish;
    end

endmodule

// File: flist.f
src/ooo_pkg.sv
src/alu_unit.sv
src/mul_unit.sv
src/div_unit.sv
src/result_bus_arbiter.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
testbench/tb_ooo_core.sv
